// ==== Makefile ====
SIM  := obj_dir/Vtb_pool_mif
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f --top-module tb_pool_mif -o Vtb_pool_mif

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
hw/pool_mif_pkg.sv
hw/prior_arb.sv
hw/mif_dispatch.sv
hw/mif_channel.sv
hw/mif_return_xbar.sv
hw/pool_mif.sv
testbench/mif_checker.sv
testbench/tb_pool_mif.sv

// ==== hw/mif_channel.sv ====
`timescale 1ns/1ps

// Fetch channel, address phase then data phase then tagged return
module mif_channel (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        clear_i,
    // From dispatcher
    input  logic                        assign_vld_i,
    input  pool_mif_pkg::addr_req_t     assign_req_i,
    output logic                        idle_o,
    // GLB address port
    output logic                        glb_addr_vld_o,
    output pool_mif_pkg::glb_addr_t     glb_addr_o,
    input  logic                        glb_addr_rdy_i,
    // GLB data port
    input  pool_mif_pkg::ofm_t          glb_ofm_i,
    input  logic                        glb_ofm_vld_i,
    output logic                        glb_ofm_rdy_o,
    // To return crossbar
    output pool_mif_pkg::tagged_ofm_t   ret_o,
    output logic                        ret_vld_o,
    input  logic                        ret_rdy_i
);

    pool_mif_pkg::chan_state_e state_q;

    // Request held for the whole round trip
    pool_mif_pkg::addr_req_t   req_q;

    // Returned word with destination tag
    pool_mif_pkg::tagged_ofm_t ret_q;

    // ====================
    // State machine
    // ====================

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            state_q <= pool_mif_pkg::CH_IDLE;
        end else begin
            case (state_q)
                pool_mif_pkg::CH_IDLE: begin
                    // Wait for dispatcher strobe
                    if (assign_vld_i) begin
                        state_q <= pool_mif_pkg::CH_ADDR;
                    end
                end
                pool_mif_pkg::CH_ADDR: begin
                    // Address accepted by GLB
                    if (glb_addr_rdy_i) begin
                        state_q <= pool_mif_pkg::CH_DATA;
                    end
                end
                pool_mif_pkg::CH_DATA: begin
                    if (glb_ofm_vld_i) begin
                        state_q <= pool_mif_pkg::CH_RET;
                    end
                end
                pool_mif_pkg::CH_RET: begin
                    // Free again once crossbar takes the word
                    if (ret_rdy_i) begin
                        state_q <= pool_mif_pkg::CH_IDLE;
                    end
                end
                default: state_q <= pool_mif_pkg::CH_IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (state_q == pool_mif_pkg::CH_IDLE && assign_vld_i) begin
            req_q <= assign_req_i;
        end
        // Tag from the stored request, data from GLB
        if (state_q == pool_mif_pkg::CH_DATA && glb_ofm_vld_i) begin
            ret_q <= '{core: req_q.core, ofm: glb_ofm_i};
        end
    end

    // ====================
    // Outputs
    // ====================

    assign idle_o         = (state_q == pool_mif_pkg::CH_IDLE);
    assign glb_addr_vld_o = (state_q == pool_mif_pkg::CH_ADDR);
    assign glb_addr_o     = req_q.addr;
    assign glb_ofm_rdy_o  = (state_q == pool_mif_pkg::CH_DATA);
    assign ret_vld_o      = (state_q == pool_mif_pkg::CH_RET);
    assign ret_o          = ret_q;

    // Word held steady while the core stalls
    a_ret_stable: assert property (
        @(posedge clk) disable iff (reset_i || clear_i)
        (ret_vld_o && !ret_rdy_i) |=> (ret_vld_o && $stable(ret_o))
    ) else $error("return payload changed under back-pressure");

    // Dispatcher only strobes idle channels
    a_assign_idle: assert property (
        @(posedge clk) disable iff (reset_i)
        assign_vld_i |-> idle_o
    ) else $error("request assigned to a busy channel");

endmodule

// ==== hw/mif_dispatch.sv ====
`timescale 1ns/1ps

// One core request per cycle goes to one idle channel
module mif_dispatch (
    input  logic                      clk,
    input  logic                      reset_i,
    // Pooling side requests
    input  pool_mif_pkg::core_vec_t   pol_addr_vld_i,
    input  pool_mif_pkg::glb_addr_t   pol_addr_i [0:pool_mif_pkg::POOL_CORE-1],
    output pool_mif_pkg::core_vec_t   pol_rdy_o,
    // Channel side
    input  pool_mif_pkg::core_vec_t   chan_idle_i,
    output pool_mif_pkg::core_vec_t   assign_vld_o,
    output pool_mif_pkg::addr_req_t   assign_req_o
);

    // ====================
    // Core arbitration
    // ====================

    pool_mif_pkg::core_vec_t core_gnt;
    pool_mif_pkg::core_idx_t core_idx;
    logic                    core_any;

    // Lowest numbered requesting core wins
    prior_arb u_core_arb (
        .req_i (pol_addr_vld_i),
        .gnt_o (core_gnt),
        .idx_o (core_idx),
        .any_o (core_any)
    );

    // ====================
    // Channel selection
    // ====================

    pool_mif_pkg::core_vec_t chan_gnt;
    logic                    chan_any;

    // Lowest numbered idle channel takes the request
    // Channel index itself not needed, strobe is one-hot
    prior_arb u_chan_arb (
        .req_i (chan_idle_i),
        .gnt_o (chan_gnt),
        .idx_o (),
        .any_o (chan_any)
    );

    // ====================
    // Handshake
    // ====================

    // Accept only when a core and a channel both win
    assign assign_vld_o = chan_any ? (core_any ? chan_gnt : '0) : '0;
    // Same pairing from both sides
    assign pol_rdy_o    = chan_any ? core_gnt & {pool_mif_pkg::POOL_CORE{core_any}} : '0;

    // Shared payload, only sampled by the strobed channel
    assign assign_req_o = '{core: core_idx, addr: pol_addr_i[core_idx]};

    // At most one channel strobed per cycle
    a_assign_onehot: assert property (
        @(posedge clk) disable iff (reset_i)
        $onehot0(assign_vld_o)
    ) else $error("dispatch strobed more than one channel");

endmodule

// ==== hw/mif_return_xbar.sv ====
`timescale 1ns/1ps

// Routes tagged words back to their cores, fixed priority per core
module mif_return_xbar (
    // From channels
    input  pool_mif_pkg::tagged_ofm_t ret_i [0:pool_mif_pkg::POOL_CORE-1],
    input  pool_mif_pkg::core_vec_t   ret_vld_i,
    output pool_mif_pkg::core_vec_t   ret_rdy_o,
    // To pooling cores
    output pool_mif_pkg::ofm_t        pol_ofm_o [0:pool_mif_pkg::POOL_CORE-1],
    output pool_mif_pkg::core_vec_t   pol_ofm_vld_o,
    input  pool_mif_pkg::core_vec_t   pol_ofm_rdy_i
);

    // Valid channels tagged for each core
    pool_mif_pkg::core_vec_t match   [0:pool_mif_pkg::POOL_CORE-1];

    // Winning channel per core, one-hot and encoded
    pool_mif_pkg::core_vec_t gnt     [0:pool_mif_pkg::POOL_CORE-1];
    pool_mif_pkg::core_idx_t win_idx [0:pool_mif_pkg::POOL_CORE-1];

    // Per channel, which cores send ready to it
    pool_mif_pkg::core_vec_t rdy_src [0:pool_mif_pkg::POOL_CORE-1];

    // ====================
    // Match vectors
    // ====================

    always_comb begin
        for (int c = 0; c < pool_mif_pkg::POOL_CORE; c++) begin
            for (int k = 0; k < pool_mif_pkg::POOL_CORE; k++) begin
                match[c][k] = ret_vld_i[k] && (ret_i[k].core == pool_mif_pkg::core_idx_t'(c));
            end
        end
    end

    // ====================
    // Per-core select
    // ====================

    for (genvar c = 0; c < pool_mif_pkg::POOL_CORE; c++) begin : g_core
        // Lowest channel index wins the core
        prior_arb u_ret_arb (
            .req_i (match[c]),
            .gnt_o (gnt[c]),
            .idx_o (win_idx[c]),
            .any_o (pol_ofm_vld_o[c])
        );

        // Data from winner only, valid gates its use
        assign pol_ofm_o[c] = ret_i[win_idx[c]].ofm;
    end

    // ====================
    // Ready steering
    // ====================

    // Transpose grants, qualify with core ready
    // A channel carries one tag, so one core at most can release it
    always_comb begin
        for (int k = 0; k < pool_mif_pkg::POOL_CORE; k++) begin
            for (int c = 0; c < pool_mif_pkg::POOL_CORE; c++) begin
                rdy_src[k][c] = gnt[c][k] && pol_ofm_rdy_i[c];
            end
            ret_rdy_o[k] = |rdy_src[k];
        end
    end

endmodule

// ==== hw/pool_mif.sv ====
`timescale 1ns/1ps

// Memory interface between pooling cores and the GLB read ports
module pool_mif (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    clear_i,
    // Pooling request side
    input  pool_mif_pkg::core_vec_t pol_addr_vld_i,
    input  pool_mif_pkg::glb_addr_t pol_addr_i     [0:pool_mif_pkg::POOL_CORE-1],
    output pool_mif_pkg::core_vec_t pol_rdy_o,
    // Pooling return side
    output pool_mif_pkg::ofm_t      pol_ofm_o      [0:pool_mif_pkg::POOL_CORE-1],
    output pool_mif_pkg::core_vec_t pol_ofm_vld_o,
    input  pool_mif_pkg::core_vec_t pol_ofm_rdy_i,
    // GLB address ports
    output pool_mif_pkg::glb_addr_t glb_addr_o     [0:pool_mif_pkg::POOL_CORE-1],
    output pool_mif_pkg::core_vec_t glb_addr_vld_o,
    input  pool_mif_pkg::core_vec_t glb_addr_rdy_i,
    // GLB data ports
    input  pool_mif_pkg::ofm_t      glb_ofm_i      [0:pool_mif_pkg::POOL_CORE-1],
    input  pool_mif_pkg::core_vec_t glb_ofm_vld_i,
    output pool_mif_pkg::core_vec_t glb_ofm_rdy_o
);

    // Dispatcher to channels
    pool_mif_pkg::core_vec_t     chan_idle;
    pool_mif_pkg::core_vec_t     assign_vld;
    pool_mif_pkg::addr_req_t     assign_req;

    // Channels to crossbar
    pool_mif_pkg::tagged_ofm_t   ret     [0:pool_mif_pkg::POOL_CORE-1];
    pool_mif_pkg::core_vec_t     ret_vld;
    pool_mif_pkg::core_vec_t     ret_rdy;

    // ====================
    // Request path
    // ====================

    mif_dispatch u_dispatch (
        .clk            (clk),
        .reset_i        (reset_i),
        .pol_addr_vld_i (pol_addr_vld_i),
        .pol_addr_i     (pol_addr_i),
        .pol_rdy_o      (pol_rdy_o),
        .chan_idle_i    (chan_idle),
        .assign_vld_o   (assign_vld),
        .assign_req_o   (assign_req)
    );

    // One channel per GLB read port
    for (genvar k = 0; k < pool_mif_pkg::POOL_CORE; k++) begin : g_chan
        mif_channel u_chan (
            .clk            (clk),
            .reset_i        (reset_i),
            .clear_i        (clear_i),
            .assign_vld_i   (assign_vld[k]),
            .assign_req_i   (assign_req),
            .idle_o         (chan_idle[k]),
            .glb_addr_vld_o (glb_addr_vld_o[k]),
            .glb_addr_o     (glb_addr_o[k]),
            .glb_addr_rdy_i (glb_addr_rdy_i[k]),
            .glb_ofm_i      (glb_ofm_i[k]),
            .glb_ofm_vld_i  (glb_ofm_vld_i[k]),
            .glb_ofm_rdy_o  (glb_ofm_rdy_o[k]),
            .ret_o          (ret[k]),
            .ret_vld_o      (ret_vld[k]),
            .ret_rdy_i      (ret_rdy[k])
        );
    end

    // ====================
    // Return path
    // ====================

    mif_return_xbar u_xbar (
        .ret_i         (ret),
        .ret_vld_i     (ret_vld),
        .ret_rdy_o     (ret_rdy),
        .pol_ofm_o     (pol_ofm_o),
        .pol_ofm_vld_o (pol_ofm_vld_o),
        .pol_ofm_rdy_i (pol_ofm_rdy_i)
    );

endmodule

// ==== hw/pool_mif_pkg.sv ====
package pool_mif_pkg;

    // ====================
    // Sizes
    // ====================

    // Pooling cores, one fetch channel per core
    localparam int POOL_CORE = 4;

    // Activation lanes in one OFM word
    localparam int POOL_COMP_CORE = 8;

    // Bits per activation
    localparam int ACT_WIDTH = 8;

    // GLB word address width
    localparam int IDX_WIDTH = 10;

    // Enough bits to name any core
    localparam int CORE_IDX_WIDTH = 2;

    // Full OFM word
    localparam int OFM_WIDTH = POOL_COMP_CORE * ACT_WIDTH;

    // ====================
    // Vector types
    // ====================

    // Index of a pooling core
    typedef logic [CORE_IDX_WIDTH-1:0] core_idx_t;

    // GLB word address
    typedef logic [IDX_WIDTH-1:0] glb_addr_t;

    // Lane j sits at bits [j*ACT_WIDTH +: ACT_WIDTH]
    typedef logic [OFM_WIDTH-1:0] ofm_t;

    // One bit per core or per channel
    typedef logic [POOL_CORE-1:0] core_vec_t;

    // ====================
    // Bundles
    // ====================

    // Dispatcher to channel, requesting core plus address
    typedef struct packed {
        core_idx_t core;
        glb_addr_t addr;
    } addr_req_t;

    // Channel to crossbar, destination core plus data
    typedef struct packed {
        core_idx_t core;
        ofm_t      ofm;
    } tagged_ofm_t;

    // Fetch channel FSM
    typedef enum logic [1:0] {
        CH_IDLE = 2'd0,
        CH_ADDR = 2'd1,
        CH_DATA = 2'd2,
        CH_RET  = 2'd3
    } chan_state_e;

endpackage

// ==== hw/prior_arb.sv ====
`timescale 1ns/1ps

// Fixed priority, bit 0 wins
module prior_arb (
    input  pool_mif_pkg::core_vec_t req_i,
    output pool_mif_pkg::core_vec_t gnt_o,
    output pool_mif_pkg::core_idx_t idx_o,
    output logic                    any_o
);

    // Isolate lowest set bit
    // Two's complement clears everything above it
    assign gnt_o = req_i & pool_mif_pkg::core_vec_t'(~req_i + 1'b1);

    // Some requester present
    assign any_o = |req_i;

    // Encoded winner
    // Scan downwards so the lowest set bit is written last
    always_comb begin
        idx_o = '0;
        for (int i = pool_mif_pkg::POOL_CORE - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                idx_o = pool_mif_pkg::core_idx_t'(i);
            end
        end
    end

endmodule

// ==== testbench/mif_checker.sv ====
`timescale 1ns/1ps

// Scoreboard on the pooling ports, also watches for stray GLB activity
module mif_checker (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    done_i,
    input  logic [8*12-1:0]         test_i,
    input  pool_mif_pkg::core_vec_t req_vld_i,
    input  pool_mif_pkg::core_vec_t req_rdy_i,
    input  pool_mif_pkg::ofm_t      exp_ofm_i [0:pool_mif_pkg::POOL_CORE-1],
    input  pool_mif_pkg::ofm_t      ofm_i     [0:pool_mif_pkg::POOL_CORE-1],
    input  pool_mif_pkg::core_vec_t ofm_vld_i,
    input  pool_mif_pkg::core_vec_t ofm_rdy_i,
    input  pool_mif_pkg::core_vec_t glb_busy_i,
    output int                      pending_o,
    output int                      errors_o
);

    // Expected words still owed, one list per core
    pool_mif_pkg::ofm_t owed [0:pool_mif_pkg::POOL_CORE-1][$];
    logic               reported;

    always @(posedge clk) begin
        int hit;
        if (reset_i) begin
            foreach (owed[c])
                owed[c].delete();
            pending_o = 0;
            errors_o  = 0;
            reported  = 1'b0;
        end else begin
            if ($countones(req_vld_i & req_rdy_i) > 1) begin
                $display("Error in %0s: two requests accepted in one cycle", test_i);
                errors_o++;
            end
            // Four outstanding means four busy channels
            if ((req_vld_i & req_rdy_i) != 0 && pending_o >= pool_mif_pkg::POOL_CORE) begin
                $display("Error in %0s: request accepted while every channel was busy", test_i);
                errors_o++;
            end
            if (glb_busy_i != 0 && pending_o == 0) begin
                $display("Error in %0s: GLB port active with no request outstanding", test_i);
                errors_o++;
            end
            for (int c = 0; c < pool_mif_pkg::POOL_CORE; c++) begin
                if (ofm_vld_i[c] && owed[c].size() == 0) begin
                    $display("Error in %0s: core %0d got a return it never asked for", test_i, c);
                    errors_o++;
                end else if (ofm_vld_i[c] && ofm_rdy_i[c]) begin
                    // Any outstanding word may come back, order is free
                    hit = -1;
                    foreach (owed[c][i])
                        if (hit < 0 && owed[c][i] == ofm_i[c])
                            hit = i;
                    if (hit < 0) begin
                        $display("Mismatch in %0s: core %0d expected %h actual %h",
                                 test_i, c, owed[c][0], ofm_i[c]);
                        errors_o++;
                        hit = 0;
                    end
                    owed[c].delete(hit);
                    pending_o--;
                end
                if (req_vld_i[c] && req_rdy_i[c]) begin
                    owed[c].push_back(exp_ofm_i[c]);
                    pending_o++;
                end
            end
            // End of run, whatever is left never came back
            if (done_i && !reported) begin
                reported = 1'b1;
                for (int c = 0; c < pool_mif_pkg::POOL_CORE; c++) begin
                    foreach (owed[c][i]) begin
                        $display("Error: core %0d is missing the return of word %h", c, owed[c][i]);
                        errors_o++;
                    end
                end
            end
        end
    end

endmodule

// ==== testbench/tb_pool_mif.sv ====
`timescale 1ns/1ps

module tb_pool_mif;

    // ====================
    // Setup
    // ====================

    // single, all cores, same core, back-pressure, after clear, soak
    localparam int N_REQ      = 1 + 4 + 4 + 6 + 1 + 200;
    localparam int MAX_CYCLES = 200 + 40 * N_REQ;

    logic                    clk;
    logic                    reset_i;
    logic                    clear_i;
    pool_mif_pkg::core_vec_t pol_addr_vld_i;
    pool_mif_pkg::glb_addr_t pol_addr_i     [0:pool_mif_pkg::POOL_CORE-1];
    pool_mif_pkg::core_vec_t pol_rdy_o;
    pool_mif_pkg::ofm_t      pol_ofm_o      [0:pool_mif_pkg::POOL_CORE-1];
    pool_mif_pkg::core_vec_t pol_ofm_vld_o;
    pool_mif_pkg::core_vec_t pol_ofm_rdy_i;
    pool_mif_pkg::glb_addr_t glb_addr_o     [0:pool_mif_pkg::POOL_CORE-1];
    pool_mif_pkg::core_vec_t glb_addr_vld_o;
    pool_mif_pkg::core_vec_t glb_addr_rdy_i;
    pool_mif_pkg::ofm_t      glb_ofm_i      [0:pool_mif_pkg::POOL_CORE-1];
    pool_mif_pkg::core_vec_t glb_ofm_vld_i;
    pool_mif_pkg::core_vec_t glb_ofm_rdy_o;

    // Expected word for whatever each core presents
    pool_mif_pkg::ofm_t      exp_ofm        [0:pool_mif_pkg::POOL_CORE-1];
    pool_mif_pkg::glb_addr_t send_q         [0:pool_mif_pkg::POOL_CORE-1][$];
    logic [8*12-1:0]         test_name;
    logic                    done;
    int                      pending;
    int                      chk_errors;
    int                      tb_errors = 0;
    int                      peak = 0;
    int                      cycles = 0;

    pool_mif dut_i (.*);

    mif_checker u_checker (
        .clk (clk), .reset_i (reset_i), .done_i (done), .test_i (test_name),
        .req_vld_i (pol_addr_vld_i), .req_rdy_i (pol_rdy_o), .exp_ofm_i (exp_ofm),
        .ofm_i (pol_ofm_o), .ofm_vld_i (pol_ofm_vld_o), .ofm_rdy_i (pol_ofm_rdy_i),
        .glb_busy_i (glb_addr_vld_o | glb_ofm_rdy_o),
        .pending_o (pending), .errors_o (chk_errors)
    );

    // Reference GLB content, lane j is low address byte plus 17*j
    function automatic pool_mif_pkg::ofm_t glb_ofm(input pool_mif_pkg::glb_addr_t addr);
        pool_mif_pkg::ofm_t word;
        for (int j = 0; j < pool_mif_pkg::POOL_COMP_CORE; j++) begin
            word[j*pool_mif_pkg::ACT_WIDTH +: pool_mif_pkg::ACT_WIDTH] = addr[7:0] + 8'(j * 17);
        end
        return word;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d returns outstanding", cycles, pending);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ====================
    // GLB read ports
    // ====================

    for (genvar k = 0; k < pool_mif_pkg::POOL_CORE; k++) begin : g_glb
        logic               addr_rdy;
        logic               ofm_vld;
        pool_mif_pkg::ofm_t ofm;
        assign glb_addr_rdy_i[k] = addr_rdy;
        assign glb_ofm_vld_i[k]  = ofm_vld;
        assign glb_ofm_i[k]      = ofm;
        assign exp_ofm[k]        = glb_ofm(pol_addr_i[k]);
        initial begin
            addr_rdy = 1'b0;
            ofm_vld  = 1'b0;
            ofm      = '0;
            forever begin
                do
                    @(posedge clk);
                while (!glb_addr_vld_o[k]);
                // Address ready after 0 to 3 cycles
                repeat ($urandom_range(3)) @(posedge clk);
                #1 addr_rdy = 1'b1;
                @(posedge clk);
                #1 addr_rdy = 1'b0;
                ofm = glb_ofm(glb_addr_o[k]);
                // Data after another 0 to 3 cycles, channel ready waits for it
                repeat ($urandom_range(3)) begin
                    @(posedge clk);
                    #1;
                end
                ofm_vld = 1'b1;
                @(posedge clk);
                #1 ofm_vld = 1'b0;
            end
        end
    end

    // ====================
    // Pooling side driver
    // ====================

    // Feeds the queued addresses, returns once every request has come back
    task automatic run_traffic(input bit rand_gap, input bit rand_rdy, input int stall_len,
                               input pool_mif_pkg::core_vec_t stall_cores);
        int                      gap [0:pool_mif_pkg::POOL_CORE-1];
        int                      stall;
        bit                      busy;
        pool_mif_pkg::core_vec_t taken;
        stall = stall_len;
        busy  = 1'b1;
        foreach (gap[c])
            gap[c] = 0;
        while (busy) begin
            @(posedge clk);
            taken = pol_addr_vld_i & pol_rdy_o;
            #1;
            busy = (pending != 0);
            for (int c = 0; c < pool_mif_pkg::POOL_CORE; c++) begin
                if (taken[c]) begin
                    void'(send_q[c].pop_front());
                    pol_addr_vld_i[c] = 1'b0;
                    gap[c] = rand_gap ? int'($urandom_range(3)) : 0;
                end
                if (!pol_addr_vld_i[c] && send_q[c].size() != 0) begin
                    if (gap[c] > 0) begin
                        gap[c]--;
                    end else begin
                        pol_addr_vld_i[c] = 1'b1;
                        pol_addr_i[c]     = send_q[c][0];
                    end
                end
                busy |= (send_q[c].size() != 0);
            end
            pol_ofm_rdy_i = rand_rdy ? pool_mif_pkg::core_vec_t'($urandom) : '1;
            if (stall > 0) begin
                pol_ofm_rdy_i &= ~stall_cores;
                stall--;
            end
            if (pending > peak)
                peak = pending;
        end
        pol_ofm_rdy_i = '1;
    endtask

    // ====================
    // Tests
    // ====================

    initial begin
        void'($urandom(94));
        reset_i        = 1'b1;
        clear_i        = 1'b0;
        done           = 1'b0;
        pol_addr_vld_i = '0;
        pol_ofm_rdy_i  = '1;
        test_name      = "reset";
        foreach (pol_addr_i[c])
            pol_addr_i[c] = '0;
        repeat (2) @(posedge clk);
        #1 reset_i = 1'b0;

        test_name = "single";
        send_q[2].push_back(10'h05a);
        run_traffic(1'b0, 1'b0, 0, '0);

        test_name = "all_cores";
        for (int c = 0; c < pool_mif_pkg::POOL_CORE; c++)
            send_q[c].push_back(pool_mif_pkg::glb_addr_t'(256 + 3 * c));
        run_traffic(1'b0, 1'b0, 0, '0);

        test_name = "same_core";
        repeat (4) send_q[1].push_back(pool_mif_pkg::glb_addr_t'($urandom_range(1023)));
        run_traffic(1'b0, 1'b0, 0, '0);

        // Core 0 stalls long enough for all channels to fill
        test_name = "backpress";
        peak = 0;
        repeat (6) send_q[0].push_back(pool_mif_pkg::glb_addr_t'($urandom_range(1023)));
        run_traffic(1'b0, 1'b0, 30, 4'b0001);
        if (peak < pool_mif_pkg::POOL_CORE) begin
            $display("Error in backpress: the channels never all filled up");
            tb_errors++;
        end

        // Quiet cycles after clear, checker flags any valid
        test_name = "clear";
        clear_i = 1'b1;
        @(posedge clk);
        #1 clear_i = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        send_q[3].push_back(10'h3c7);
        run_traffic(1'b0, 1'b0, 0, '0);

        test_name = "soak";
        repeat (200) begin
            send_q[$urandom_range(3)].push_back(pool_mif_pkg::glb_addr_t'($urandom_range(1023)));
        end
        run_traffic(1'b1, 1'b1, 0, '0);

        done = 1'b1;
        repeat (2) @(posedge clk);
        $display("Errors: checker %0d, bench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
